// File: project.f
hdl/ec_pkg.sv
hdl/leading_zero.sv
hdl/ec_bool_step.sv
hdl/ec_decode.sv
hdl/ec_execute.sv
hdl/ec_result.sv
hdl/ec_top.sv
verif/tb_ec_top.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_ec_top
RTL_TOP    = ec_top
FILELIST   = project.f
OBJ_DIR    = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_ec_top.sv
// Testbench for ec_top with seeded random stimulus, reference model, checks and watchdog
`timescale 1ns/1ps

module tb_ec_top import ec_pkg::*; ();

  // Operation counts per test
  localparam int n_iso   = 40;
  localparam int n_bool  = 60;
  localparam int n_b2b   = 200;
  localparam int n_gap   = 30;
  localparam int n_long  = 600;
  localparam int n_total = n_iso + n_bool + n_b2b + n_gap + n_long;
  // Four cycles per operation plus the reset
  localparam int limit_cycles = n_total * 4 + 16;

  logic        clk;
  logic        rst_n;
  logic        op_valid;
  ec_op_e      op_kind;
  logic [15:0] cdf_fl;
  logic [15:0] cdf_fh;
  logic [3:0]  sym;
  logic [4:0]  n_syms;
  logic [1:0]  bool_count;
  logic [2:0]  bool_bits;
  logic        done;
  logic [15:0] range;
  logic [31:0] low;
  logic [4:0]  shift;

  integer seed = 32'hdfdd_cd77;
  int cyc = 0;
  int errs = 0;
  int checks = 0;
  int n_ops = 0;
  int n_done = 0;

  // Model state
  logic [15:0] m_range;
  logic [31:0] m_low;
  bit          wrapped;

  // Expected results in issue order
  logic [15:0] exp_range_q[$];
  logic [31:0] exp_low_q[$];
  logic [4:0]  exp_shift_q[$];
  int          exp_cyc_q[$];

  // Values seen at the last done
  logic [15:0] last_range;
  logic [31:0] last_low;
  logic [4:0]  last_shift;

  ec_top u_ec_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_valid   (op_valid),
    .op_kind    (op_kind),
    .cdf_fl     (cdf_fl),
    .cdf_fh     (cdf_fh),
    .sym        (sym),
    .n_syms     (n_syms),
    .bool_count (bool_count),
    .bool_bits  (bool_bits),
    .done       (done),
    .range      (range),
    .low        (low),
    .shift      (shift)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Drive edges read the count before its own increment
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("error at time %0t: %s expected %0h got %0h", $time, name, exp, act);
      errs++;
    end
  endtask

  // Scan from the top bit down
  function automatic logic [4:0] count_lz(input logic [15:0] x);
    for (int i = 15; i >= 0; i--) begin
      if (x[i]) begin
        return 5'(15 - i);
      end
    end
    return 5'd16;
  endfunction

  // Gain then shift, low kept modulo 2^32
  task automatic model_apply(input logic [15:0] raw, input logic [15:0] gain,
                             input logic [4:0] d);
    logic [63:0] wide;
    wide = (64'(m_low) + 64'(gain)) << d;
    if (wide[63:32] != 32'd0) begin
      wrapped = 1'b1;
    end
    m_low   = wide[31:0];
    m_range = raw << d;
  endtask

  task automatic model_cdf(input int fl, input int fh, input int s, input int n,
                           output logic [4:0] d);
    int r;
    int rr;
    int u;
    int v;
    int raw;
    int gain;
    r  = int'(m_range);
    rr = r >> 8;
    u  = ((rr * (fl >> 6)) >> 1) + 4 * (n - s);
    v  = ((rr * (fh >> 6)) >> 1) + 4 * (n - 1 - s);
    if (s != 0) begin
      raw  = u - v;
      gain = r - u;
    end else begin
      // Symbol 0 keeps low
      raw  = r - v;
      gain = 0;
    end
    d = count_lz(16'(raw));
    model_apply(16'(raw), 16'(gain), d);
  endtask

  task automatic model_bool(input logic b, output logic [4:0] d);
    int r;
    int v;
    int raw;
    int gain;
    r = int'(m_range);
    v = ((r >> 8) << 7) + 4;
    raw  = b ? v : r - v;
    gain = b ? r - v : 0;
    // Raw range stays above 2^13 so two shifts at most
    d = (raw >= 32768) ? 5'd0 : (raw >= 16384) ? 5'd1 : 5'd2;
    model_apply(16'(raw), 16'(gain), d);
  endtask

  task automatic push_expect(input logic [4:0] sh);
    exp_range_q.push_back(m_range);
    exp_low_q.push_back(m_low);
    exp_shift_q.push_back(sh);
    // Done shows at the negedge after two more edges
    exp_cyc_q.push_back(cyc + 3);
    n_ops++;
  endtask

  task automatic drive_cdf(input bit zero_sym);
    int n;
    int s;
    logic [15:0] fl;
    logic [15:0] fh;
    logic [4:0] d;
    n = 2 + int'($unsigned($random(seed)) % 15);
    s = zero_sym ? 0 : int'($unsigned($random(seed)) % n);
    fl = (s == 0) ? 16'd32768 : 16'(1 + $unsigned($random(seed)) % 32767);
    // Last symbol closes the CDF at zero
    fh = (s == n - 1) ? 16'd0 : 16'($unsigned($random(seed)) % fl);
    @(posedge clk);
    op_valid <= 1'b1;
    op_kind  <= op_cdf;
    cdf_fl   <= fl;
    cdf_fh   <= fh;
    sym      <= 4'(s);
    n_syms   <= 5'(n);
    model_cdf(int'(fl), int'(fh), s, n, d);
    push_expect(d);
  endtask

  task automatic drive_bool(input int cnt);
    logic [2:0] bits;
    logic [4:0] d;
    logic [4:0] total;
    bits  = 3'($random(seed));
    total = 5'd0;
    @(posedge clk);
    op_valid   <= 1'b1;
    op_kind    <= op_bool;
    bool_count <= 2'(cnt);
    bool_bits  <= bits;
    // Bit 0 is coded first
    for (int k = 0; k < cnt; k++) begin
      model_bool(bits[k], d);
      total = total + d;
    end
    push_expect(total);
  endtask

  task automatic drive_any();
    if ($unsigned($random(seed)) % 2 == 0) begin
      drive_cdf(1'b0);
    end else begin
      drive_bool(1 + int'($unsigned($random(seed)) % 3));
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      op_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_range_q.size() != 0) begin
      @(posedge clk);
    end
    idle(2);
  endtask

  task automatic report_test(input string name, input int e0, input int c0);
    $display("test %s: %0d checks, %0d errors", name, checks - c0, errs - e0);
  endtask

  // Output monitor at the falling edge where outputs are stable
  always @(negedge clk) begin : monitor
    int exp_c;
    if (!rst_n) begin
      last_range = range_init;
      last_low   = '0;
      last_shift = '0;
    end else if (done) begin
      n_done++;
      assert (exp_range_q.size() != 0) else begin
        $display("done pulse at time %0t with no operation pending", $time);
        errs++;
      end
      if (exp_range_q.size() != 0) begin
        compare_value("range", 32'(exp_range_q.pop_front()), 32'(range));
        compare_value("low", exp_low_q.pop_front(), low);
        compare_value("shift", 32'(exp_shift_q.pop_front()), 32'(shift));
        exp_c = exp_cyc_q.pop_front();
        assert (cyc == exp_c) else begin
          $display("done arrived at cycle %0d instead of cycle %0d", cyc, exp_c);
          errs++;
        end
      end
      last_range = range;
      last_low   = low;
      last_shift = shift;
    end else begin
      // No done, no state change
      compare_value("range", 32'(last_range), 32'(range));
      compare_value("low", last_low, low);
      compare_value("shift", 32'(last_shift), 32'(shift));
    end
  end

  initial begin
    int e0;
    int c0;
    rst_n      = 1'b0;
    op_valid   = 1'b0;
    op_kind    = op_cdf;
    cdf_fl     = '0;
    cdf_fh     = '0;
    sym        = '0;
    n_syms     = 5'd2;
    bool_count = 2'd1;
    bool_bits  = '0;
    m_range    = range_init;
    m_low      = '0;
    wrapped    = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values through idle cycles
    e0 = errs;
    c0 = checks;
    repeat (8) begin
      @(negedge clk);
      compare_value("done", 32'd0, 32'(done));
      compare_value("range", 32'd32768, 32'(range));
      compare_value("low", 32'd0, low);
      compare_value("shift", 32'd0, 32'(shift));
    end
    report_test("after_reset", e0, c0);

    // Isolated CDF symbols, every fourth one is symbol 0
    e0 = errs;
    c0 = checks;
    for (int i = 0; i < n_iso; i++) begin
      drive_cdf(i % 4 == 0);
      idle(1 + int'($unsigned($random(seed)) % 2));
    end
    drain();
    report_test("cdf_isolated", e0, c0);

    e0 = errs;
    c0 = checks;
    for (int i = 0; i < n_bool; i++) begin
      drive_bool(1 + i % 3);
      idle(1 + int'($unsigned($random(seed)) % 2));
    end
    drain();
    report_test("bool_counts", e0, c0);

    // Strobe every cycle, two operations in flight
    e0 = errs;
    c0 = checks;
    for (int i = 0; i < n_b2b; i++) begin
      drive_any();
    end
    drain();
    report_test("back_to_back", e0, c0);

    e0 = errs;
    c0 = checks;
    for (int i = 0; i < n_gap; i++) begin
      drive_any();
      idle(2);
    end
    drain();
    report_test("idle_gaps", e0, c0);

    // Long run, low must wrap at least once
    e0 = errs;
    c0 = checks;
    wrapped = 1'b0;
    for (int i = 0; i < n_long; i++) begin
      drive_any();
    end
    drain();
    assert (wrapped) else begin
      $display("low never wrapped past 32 bits in the long run");
      errs++;
    end
    report_test("long_random", e0, c0);

    $display("summary: %0d operations, %0d done pulses, %0d checks, %0d errors",
             n_ops, n_done, checks, errs);
    if (errs == 0 && n_done == n_ops) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin : watchdog
    #(limit_cycles * 8);
    $display("watchdog expired before all operations finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: hdl/ec_top.sv
// Range encoder top level joining decode, execute and result stages
`timescale 1ns/1ps

module ec_top import ec_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid,
  input  ec_op_e                 op_kind,
  input  logic [prob_width-1:0]  cdf_fl,
  input  logic [prob_width-1:0]  cdf_fh,
  input  logic [3:0]             sym,
  input  logic [4:0]             n_syms,
  input  logic [1:0]             bool_count,
  input  logic [max_bools-1:0]   bool_bits,
  output logic                   done,
  output logic [range_width-1:0] range,
  output logic [low_width-1:0]   low,
  output logic [d_size-1:0]      shift
);

  // Decode register outputs
  logic                   dec_valid;
  logic [range_width-1:0] uu;
  logic [range_width-1:0] vv;
  logic [range_width-1:0] lut_u;
  logic [range_width-1:0] lut_v;
  logic [range_width-1:0] lut_uv;
  logic                   comp_u;
  logic                   bool_flag_1;
  logic                   bool_flag_2;
  logic                   bool_flag_3;
  logic                   bool_bit_1;
  logic                   bool_bit_2;
  logic                   bool_bit_3;

  // Execute results
  logic [range_width-1:0] new_range;
  logic [range_width-1:0] low_add_cdf;
  logic [d_size-1:0]      shift_cdf;
  logic [range_width-1:0] low_add_1;
  logic [range_width-1:0] low_add_2;
  logic [range_width-1:0] low_add_3;
  logic [d_size-1:0]      shift_1;
  logic [d_size-1:0]      shift_2;
  logic [d_size-1:0]      shift_3;

  ec_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .op_valid    (op_valid),
    .op_kind     (op_kind),
    .cdf_fl      (cdf_fl),
    .cdf_fh      (cdf_fh),
    .sym         (sym),
    .n_syms      (n_syms),
    .bool_count  (bool_count),
    .bool_bits   (bool_bits),
    .dec_valid   (dec_valid),
    .uu          (uu),
    .vv          (vv),
    .lut_u       (lut_u),
    .lut_v       (lut_v),
    .lut_uv      (lut_uv),
    .comp_u      (comp_u),
    .bool_flag_1 (bool_flag_1),
    .bool_flag_2 (bool_flag_2),
    .bool_flag_3 (bool_flag_3),
    .bool_bit_1  (bool_bit_1),
    .bool_bit_2  (bool_bit_2),
    .bool_bit_3  (bool_bit_3)
  );

  // Works on the live range so back-to-back operations chain exactly
  ec_execute u_execute (
    .range_cur   (range),
    .uu          (uu),
    .vv          (vv),
    .lut_u       (lut_u),
    .lut_v       (lut_v),
    .lut_uv      (lut_uv),
    .comp_u      (comp_u),
    .bool_flag_1 (bool_flag_1),
    .bool_flag_2 (bool_flag_2),
    .bool_flag_3 (bool_flag_3),
    .bool_bit_1  (bool_bit_1),
    .bool_bit_2  (bool_bit_2),
    .bool_bit_3  (bool_bit_3),
    .new_range   (new_range),
    .low_add_cdf (low_add_cdf),
    .shift_cdf   (shift_cdf),
    .low_add_1   (low_add_1),
    .low_add_2   (low_add_2),
    .low_add_3   (low_add_3),
    .shift_1     (shift_1),
    .shift_2     (shift_2),
    .shift_3     (shift_3)
  );

  ec_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_valid   (dec_valid),
    .new_range   (new_range),
    .low_add_cdf (low_add_cdf),
    .shift_cdf   (shift_cdf),
    .low_add_1   (low_add_1),
    .low_add_2   (low_add_2),
    .low_add_3   (low_add_3),
    .shift_1     (shift_1),
    .shift_2     (shift_2),
    .shift_3     (shift_3),
    .bool_flag_1 (bool_flag_1),
    .bool_flag_2 (bool_flag_2),
    .bool_flag_3 (bool_flag_3),
    .done        (done),
    .range       (range),
    .low         (low),
    .shift       (shift)
  );

endmodule

// File: hdl/ec_result.sv
// Result stage with range and low state, low increment and shift, done strobe
`timescale 1ns/1ps

module ec_result import ec_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dec_valid,
  input  logic [range_width-1:0] new_range,
  input  logic [range_width-1:0] low_add_cdf,
  input  logic [d_size-1:0]      shift_cdf,
  input  logic [range_width-1:0] low_add_1,
  input  logic [range_width-1:0] low_add_2,
  input  logic [range_width-1:0] low_add_3,
  input  logic [d_size-1:0]      shift_1,
  input  logic [d_size-1:0]      shift_2,
  input  logic [d_size-1:0]      shift_3,
  input  logic                   bool_flag_1,
  input  logic                   bool_flag_2,
  input  logic                   bool_flag_3,
  output logic                   done,
  output logic [range_width-1:0] range,
  output logic [low_width-1:0]   low,
  output logic [d_size-1:0]      shift
);

  logic [low_width-1:0] low_next;
  logic [d_size-1:0]    shift_next;

  // Add the gain then renormalize, wraps modulo 2^32
  function automatic logic [low_width-1:0] low_step(
    input logic [low_width-1:0]   low_in,
    input logic [range_width-1:0] add,
    input logic [d_size-1:0]      d
  );
    low_step = (low_in + low_width'(add)) << d;
  endfunction

  // Coding order matters since each shift scales the earlier gains
  always_comb begin
    low_next   = low;
    shift_next = '0;
    if (bool_flag_1) begin
      low_next   = low_step(low_next, low_add_1, shift_1);
      shift_next = shift_1;
      if (bool_flag_2) begin
        low_next   = low_step(low_next, low_add_2, shift_2);
        shift_next = shift_next + shift_2;
      end
      if (bool_flag_3) begin
        low_next   = low_step(low_next, low_add_3, shift_3);
        shift_next = shift_next + shift_3;
      end
    end else begin
      // Single CDF symbol
      low_next   = low_step(low, low_add_cdf, shift_cdf);
      shift_next = shift_cdf;
    end
  end

  // State only moves on a decoded operation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done  <= 1'b0;
      range <= range_init;
      low   <= '0;
      shift <= '0;
    end else begin
      done <= dec_valid;
      if (dec_valid) begin
        range <= new_range;
        low   <= low_next;
        shift <= shift_next;
      end
    end
  end

endmodule

// File: hdl/ec_execute.sv
// Execute stage with CDF split, leading-zero renormalization and chained boolean steps
`timescale 1ns/1ps

module ec_execute import ec_pkg::*; (
  input  logic [range_width-1:0] range_cur,
  input  logic [range_width-1:0] uu,
  input  logic [range_width-1:0] vv,
  input  logic [range_width-1:0] lut_u,
  input  logic [range_width-1:0] lut_v,
  input  logic [range_width-1:0] lut_uv,
  input  logic                   comp_u,
  input  logic                   bool_flag_1,
  input  logic                   bool_flag_2,
  input  logic                   bool_flag_3,
  input  logic                   bool_bit_1,
  input  logic                   bool_bit_2,
  input  logic                   bool_bit_3,
  output logic [range_width-1:0] new_range,
  output logic [range_width-1:0] low_add_cdf,
  output logic [d_size-1:0]      shift_cdf,
  output logic [range_width-1:0] low_add_1,
  output logic [range_width-1:0] low_add_2,
  output logic [range_width-1:0] low_add_3,
  output logic [d_size-1:0]      shift_1,
  output logic [d_size-1:0]      shift_2,
  output logic [d_size-1:0]      shift_3
);

  logic [range_width-1:0]   rr;
  logic [2*range_width-1:0] prod_u;
  logic [2*range_width-1:0] prod_v;
  logic [range_width-1:0]   tu;
  logic [range_width-1:0]   tv;
  logic [range_width-1:0]   u;
  logic [range_width-1:0]   raw_u;
  logic [range_width-1:0]   raw_v;
  logic [range_width-1:0]   raw_cdf;
  logic [d_size-1:0]        d_cdf;
  logic [range_width-1:0]   range_cdf;
  logic [range_width-1:0]   range_b1;
  logic [range_width-1:0]   range_b2;
  logic [range_width-1:0]   range_b3;

  // Top byte of the range drives both products
  assign rr = range_cur >> 8;

  // Products stay below 2^17
  assign prod_u = rr * uu;
  assign prod_v = rr * vv;
  assign tu     = prod_u[range_width:1];
  assign tv     = prod_v[range_width:1];

  // Full u is only needed for the low gain
  assign u = tu + lut_u;

  // u - v with the lookup difference added once
  assign raw_u = (tu - tv) + lut_uv;
  // r - v with v = tv + lut_v
  assign raw_v = (range_cur - lut_v) - tv;

  // Symbol 0 keeps the top of the interval
  assign raw_cdf     = comp_u ? raw_u : raw_v;
  assign low_add_cdf = comp_u ? (range_cur - u) : '0;

  // CDF renormalization by leading-zero count
  leading_zero u_lzc (
    .in_range (raw_cdf),
    .lzc_out  (d_cdf)
  );

  assign range_cdf = raw_cdf << d_cdf;
  assign shift_cdf = d_cdf;

  // Boolean chain, each step starts from the previous range
  ec_bool_step u_bool_1 (
    .in_range  (range_cur),
    .in_bit    (bool_bit_1),
    .out_range (range_b1),
    .low_add   (low_add_1),
    .out_d     (shift_1)
  );

  ec_bool_step u_bool_2 (
    .in_range  (range_b1),
    .in_bit    (bool_bit_2),
    .out_range (range_b2),
    .low_add   (low_add_2),
    .out_d     (shift_2)
  );

  ec_bool_step u_bool_3 (
    .in_range  (range_b2),
    .in_bit    (bool_bit_3),
    .out_range (range_b3),
    .low_add   (low_add_3),
    .out_d     (shift_3)
  );

  // Last enabled boolean step wins
  // CDF path when no boolean is enabled
  assign new_range = bool_flag_3 ? range_b3 :
                     bool_flag_2 ? range_b2 :
                     bool_flag_1 ? range_b1 :
                     range_cdf;

endmodule

// File: hdl/ec_decode.sv
// Decode stage registering one operation with scaled CDF factors, lookup terms and flags
`timescale 1ns/1ps

module ec_decode import ec_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid,
  input  ec_op_e                 op_kind,
  input  logic [prob_width-1:0]  cdf_fl,
  input  logic [prob_width-1:0]  cdf_fh,
  input  logic [3:0]             sym,
  input  logic [4:0]             n_syms,
  input  logic [1:0]             bool_count,
  input  logic [max_bools-1:0]   bool_bits,
  output logic                   dec_valid,
  output logic [range_width-1:0] uu,
  output logic [range_width-1:0] vv,
  output logic [range_width-1:0] lut_u,
  output logic [range_width-1:0] lut_v,
  output logic [range_width-1:0] lut_uv,
  output logic                   comp_u,
  output logic                   bool_flag_1,
  output logic                   bool_flag_2,
  output logic                   bool_flag_3,
  output logic                   bool_bit_1,
  output logic                   bool_bit_2,
  output logic                   bool_bit_3
);

  logic [range_width-1:0] lut_u_d;
  logic [range_width-1:0] lut_v_d;
  logic                   is_bool;

  // Alphabet terms, 4 * (N - s) and 4 * (N - 1 - s)
  assign lut_u_d = (range_width'(n_syms) - range_width'(sym)) << 2;
  assign lut_v_d = (range_width'(n_syms) - range_width'(sym) - 16'd1) << 2;
  assign is_bool = (op_kind == op_bool);

  // Only the strobe carries reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= op_valid;
    end
  end

  // Operation fields loaded once per strobe
  always_ff @(posedge clk) begin
    if (op_valid) begin
      // Q15 bounds scaled down to 10 bits
      uu          <= range_width'(cdf_fl >> 6);
      vv          <= range_width'(cdf_fh >> 6);
      lut_u       <= lut_u_d;
      lut_v       <= lut_v_d;
      // Lookup difference folded into u - v
      lut_uv      <= lut_u_d - lut_v_d;
      // Symbol 0 leaves low alone
      comp_u      <= (sym != 4'd0);
      // Boolean enables by count, all clear for CDF
      bool_flag_1 <= is_bool && (bool_count >= 2'd1);
      bool_flag_2 <= is_bool && (bool_count >= 2'd2);
      bool_flag_3 <= is_bool && (bool_count == 2'd3);
      bool_bit_1  <= bool_bits[0];
      bool_bit_2  <= bool_bits[1];
      bool_bit_3  <= bool_bits[2];
    end
  end

endmodule

// File: hdl/ec_bool_step.sv
// One equiprobable boolean split with two-way renormalization mux
`timescale 1ns/1ps

module ec_bool_step import ec_pkg::*; (
  input  logic [range_width-1:0] in_range,
  input  logic                   in_bit,
  output logic [range_width-1:0] out_range,
  output logic [range_width-1:0] low_add,
  output logic [d_size-1:0]      out_d
);

  logic [range_width-1:0] v;
  logic [range_width-1:0] rest;
  logic [range_width-1:0] raw;

  // Half probability split
  // Q15 16384 >> 6 = 256 turns the product into a shift by 7
  assign v    = ((in_range >> 8) << 7) + 16'd4;
  assign rest = in_range - v;

  // Bit 1 takes the lower part and low skips the upper part
  assign raw     = in_bit ? v : rest;
  assign low_add = in_bit ? rest : '0;

  // Raw range never drops below 16380
  // Top two bits decide a shift of 0, 1 or 2
  assign out_d = raw[range_width-1] ? d_size'(0) :
                 raw[range_width-2] ? d_size'(1) :
                 d_size'(2);

  assign out_range = raw << out_d;

endmodule

// File: hdl/leading_zero.sv
// Leading-zero counter for the 16-bit CDF raw range
`timescale 1ns/1ps

module leading_zero import ec_pkg::*; (
  input  logic [range_width-1:0] in_range,
  output logic [d_size-1:0]      lzc_out
);

  // Priority encoder scanning upward
  // The highest set bit wins since it is assigned last
  always_comb begin
    // All zero input gives full width
    lzc_out = d_size'(range_width);
    for (int i = 0; i < range_width; i++) begin
      if (in_range[i]) begin
        lzc_out = d_size'(range_width - 1 - i);
      end
    end
  end

  // A renormalized range keeps bit 15 set
  // so the count lands in 0 to 15 for legal symbols

endmodule

// File: hdl/ec_pkg.sv
// Range encoder widths, reset constants and operation kind enum
package ec_pkg;

  // Range register and range arithmetic width
  localparam int range_width = 16;

  // Q15 inverse CDF bound width
  localparam int prob_width = 16;

  // Renormalization shift count width
  localparam int d_size = 5;

  // Low register width
  // Carries out of the top bit are dropped
  localparam int low_width = 32;

  // Booleans coded per operation at most
  localparam int max_bools = 3;

  // Range value after reset
  localparam logic [range_width-1:0] range_init = 16'd32768;

  // Kind of one accepted operation
  typedef enum logic {
    // Single CDF coded symbol
    op_cdf  = 1'b0,
    // One to three equiprobable booleans
    op_bool = 1'b1
  } ec_op_e;

endpackage
